// File: fetch_pkg.sv
// ------------------------------------------------
// widths, cause codes and the cause word for the
// fetch front end, imported by every design module
// ------------------------------------------------
`default_nettype none

package fetch_pkg;

  // ------------------------------------------------
  // sizes
  // ------------------------------------------------
  localparam int XLEN_W       = 32;
  localparam int FETCH_BYTES  = 8;
  localparam int FETCH_OFS_W  = $clog2(FETCH_BYTES);  // byte offset in a block
  localparam int FETCH_DATA_W = FETCH_BYTES * 8;
  localparam int MEDELEG_W    = 16;

  localparam logic [XLEN_W-1:0] RESET_VECTOR = 32'h0000_1000;

  // csr select on the write port
  localparam int CSR_ADDR_W = 3;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 3'd0;
  localparam logic [CSR_ADDR_W-1:0] CSR_STVEC   = 3'd1;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 3'd2;
  localparam logic [CSR_ADDR_W-1:0] CSR_SEPC    = 3'd3;
  localparam logic [CSR_ADDR_W-1:0] CSR_UEPC    = 3'd4;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEDELEG = 3'd5;

  // ------------------------------------------------
  // cause codes
  // ------------------------------------------------
  localparam int CAUSE_W = 5;

  // interrupts, only meaningful with int_valid set
  localparam logic [CAUSE_W-1:0] SUPER_SOFT_INT    = 5'd1;
  localparam logic [CAUSE_W-1:0] MACHINE_SOFT_INT  = 5'd3;
  localparam logic [CAUSE_W-1:0] SUPER_TIMER_INT   = 5'd5;
  localparam logic [CAUSE_W-1:0] MACHINE_TIMER_INT = 5'd7;
  localparam logic [CAUSE_W-1:0] SUPER_EXT_INT     = 5'd9;
  localparam logic [CAUSE_W-1:0] MACHINE_EXT_INT   = 5'd11;

  // synchronous exceptions, 10 and 14 unused
  localparam logic [CAUSE_W-1:0] INST_ADDR_MISALIGN  = 5'd0;
  localparam logic [CAUSE_W-1:0] INST_ACC_FAULT      = 5'd1;
  localparam logic [CAUSE_W-1:0] ILLEGAL_INST        = 5'd2;
  localparam logic [CAUSE_W-1:0] BREAKPOINT          = 5'd3;
  localparam logic [CAUSE_W-1:0] LOAD_ADDR_MISALIGN  = 5'd4;
  localparam logic [CAUSE_W-1:0] LOAD_ACC_FAULT      = 5'd5;
  localparam logic [CAUSE_W-1:0] STAMO_ADDR_MISALIGN = 5'd6;
  localparam logic [CAUSE_W-1:0] STAMO_ACC_FAULT     = 5'd7;
  localparam logic [CAUSE_W-1:0] ECALL_U             = 5'd8;
  localparam logic [CAUSE_W-1:0] ECALL_S             = 5'd9;
  localparam logic [CAUSE_W-1:0] ECALL_M             = 5'd11;
  localparam logic [CAUSE_W-1:0] INST_PAGE_FAULT     = 5'd12;
  localparam logic [CAUSE_W-1:0] LOAD_PAGE_FAULT     = 5'd13;
  localparam logic [CAUSE_W-1:0] STAMO_PAGE_FAULT    = 5'd15;

  // internal flushes raised by commit
  localparam logic [CAUSE_W-1:0] SILENT_FLUSH     = 5'd16;
  localparam logic [CAUSE_W-1:0] SELF_KILL_REPLAY = 5'd17;
  localparam logic [CAUSE_W-1:0] ANOTHER_FLUSH    = 5'd18;
  localparam logic [CAUSE_W-1:0] MRET             = 5'd19;
  localparam logic [CAUSE_W-1:0] SRET             = 5'd20;
  localparam logic [CAUSE_W-1:0] URET             = 5'd21;

  // one cause word, read as interrupt code when int_valid,
  // as exception / flush code otherwise
  typedef union packed {
    logic [CAUSE_W-1:0] int_code;
    logic [CAUSE_W-1:0] exc_code;
  } cause_u;

endpackage

`default_nettype wire

// File: fetch_wb_master.sv
// ------------------------------------------------
// fetch address register and wishbone classic
// reader for one aligned block per transfer
// ------------------------------------------------
`default_nettype none

module fetch_wb_master
  import fetch_pkg::*;
(
  input  wire logic                    i_clk,
  input  wire logic                    i_arst_n,

  // from the address generator
  input  wire logic [XLEN_W-1:0]       i_next_vaddr,
  input  wire logic                    i_redirect,

  // back to the address generator
  output logic      [XLEN_W-1:0]       o_f0_vaddr,
  output logic                         o_f0_req_ready,

  // wishbone classic master
  output logic                         o_wb_cyc,
  output logic                         o_wb_stb,
  output logic      [XLEN_W-1:0]       o_wb_adr,
  output logic                         o_wb_we,
  input  wire logic                    i_wb_ack,
  input  wire logic [FETCH_DATA_W-1:0] i_wb_dat,

  // fetched block
  output logic                         o_fetch_valid,
  output logic      [XLEN_W-1:0]       o_fetch_vaddr,
  output logic      [FETCH_DATA_W-1:0] o_fetch_data
);

  logic [XLEN_W-1:0] f0_vaddr_q;
  logic              busy_q;      // 0 idle / gap, 1 transfer on the bus
  logic              ack_hit;

  assign ack_hit = busy_q & i_wb_ack;  // ack while idle is a stale one

  // ------------------------------------------------
  // address register and bus state
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      f0_vaddr_q <= RESET_VECTOR;
      busy_q     <= 1'b0;
    end else begin
      f0_vaddr_q <= i_next_vaddr;  // holds via the generator while waiting
      if (i_redirect) begin
        busy_q <= 1'b0;            // abort, restart after one idle cycle
      end else if (!busy_q) begin
        busy_q <= 1'b1;
      end else if (i_wb_ack) begin
        busy_q <= 1'b0;            // gap cycle after each ack
      end
    end
  end

  assign o_wb_cyc = busy_q;
  assign o_wb_stb = busy_q;
  assign o_wb_adr = {f0_vaddr_q[XLEN_W-1:FETCH_OFS_W], {FETCH_OFS_W{1'b0}}};
  assign o_wb_we  = 1'b0;          // reads only

  assign o_f0_vaddr     = f0_vaddr_q;
  assign o_f0_req_ready = ack_hit;

  // block reported only if no redirect lands in the ack cycle
  assign o_fetch_valid = ack_hit & ~i_redirect;
  assign o_fetch_vaddr = f0_vaddr_q;
  assign o_fetch_data  = i_wb_dat;

endmodule

`default_nettype wire

// File: filelist.f
fetch_pkg.sv
trap_csr_regs.sv
front_addr_gen.sv
fetch_wb_master.sv
front_end_top.sv
front_end_assert.sv
tb_front_end.sv

// File: front_addr_gen.sv
// ------------------------------------------------
// next fetch address select: commit flush, then
// mispredict, then stall hold, then next block
// ------------------------------------------------
`default_nettype none

module front_addr_gen
  import fetch_pkg::*;
(
  // commit flush
  input  wire logic                 i_commit_flush,
  input  wire logic                 i_commit_int_valid,
  input  wire cause_u               i_commit_cause,
  input  wire logic [XLEN_W-1:0]    i_commit_epc,

  // branch update
  input  wire logic                 i_br_update,
  input  wire logic                 i_br_dead,
  input  wire logic                 i_br_mispredict,
  input  wire logic [XLEN_W-1:0]    i_br_target,

  // trap csr values
  input  wire logic [XLEN_W-1:0]    i_mtvec,
  input  wire logic [XLEN_W-1:0]    i_stvec,
  input  wire logic [XLEN_W-1:0]    i_mepc,
  input  wire logic [XLEN_W-1:0]    i_sepc,
  input  wire logic [XLEN_W-1:0]    i_uepc,
  input  wire logic [MEDELEG_W-1:0] i_medeleg,

  // fetch stage state
  input  wire logic                 i_f0_req_ready,
  input  wire logic [XLEN_W-1:0]    i_f0_vaddr,

  output logic      [XLEN_W-1:0]    o_vaddr,
  output logic                      o_redirect,
  output logic                      o_int_flush_valid
);

  logic              br_flush;
  logic [XLEN_W-1:0] int_base;   // mtvec with mode bit cleared
  logic [XLEN_W-1:0] int_ofs;    // code * 4
  logic [XLEN_W-1:0] block_base;

  assign br_flush   = i_br_update & ~i_br_dead & i_br_mispredict;
  assign int_base   = {i_mtvec[XLEN_W-1:1], 1'b0};
  assign int_ofs    = {{(XLEN_W-CAUSE_W-2){1'b0}}, i_commit_cause.int_code, 2'b00};
  assign block_base = {i_f0_vaddr[XLEN_W-1:FETCH_OFS_W], {FETCH_OFS_W{1'b0}}};

  assign o_redirect = i_commit_flush | br_flush;

  // ------------------------------------------------
  // address select
  // ------------------------------------------------
  always_comb begin
    o_vaddr           = '0;
    o_int_flush_valid = 1'b0;
    if (i_commit_flush) begin
      if (i_commit_int_valid) begin
        // vectored handler
        case (i_commit_cause.int_code)
          SUPER_SOFT_INT,
          MACHINE_SOFT_INT,
          SUPER_TIMER_INT,
          MACHINE_TIMER_INT,
          SUPER_EXT_INT,
          MACHINE_EXT_INT: begin
            o_vaddr           = int_base + int_ofs;
            o_int_flush_valid = 1'b1;
          end
          default: o_vaddr = '0;  // unknown interrupt
        endcase
      end else begin
        case (i_commit_cause.exc_code)
          SILENT_FLUSH:     o_vaddr = i_commit_epc + XLEN_W'(4);
          SELF_KILL_REPLAY: o_vaddr = i_commit_epc;
          ANOTHER_FLUSH:    o_vaddr = i_commit_epc;
          MRET:             o_vaddr = i_mepc;
          SRET:             o_vaddr = i_sepc;
          URET:             o_vaddr = i_uepc;
          INST_ADDR_MISALIGN,
          INST_ACC_FAULT,
          ILLEGAL_INST,
          BREAKPOINT,
          LOAD_ADDR_MISALIGN,
          LOAD_ACC_FAULT,
          STAMO_ADDR_MISALIGN,
          STAMO_ACC_FAULT,
          ECALL_U,
          ECALL_S,
          ECALL_M,
          INST_PAGE_FAULT,
          LOAD_PAGE_FAULT,
          STAMO_PAGE_FAULT: begin
            // delegated to supervisor when medeleg says so
            if (i_medeleg[i_commit_cause.exc_code[3:0]]) begin
              o_vaddr = i_stvec;
            end else begin
              o_vaddr = i_mtvec;
            end
          end
          default: o_vaddr = '0;  // 10, 14, 22 and up
        endcase
      end
    end else if (br_flush) begin
      o_vaddr = i_br_target;
    end else if (!i_f0_req_ready) begin
      o_vaddr = i_f0_vaddr;  // waiting on ack
    end else begin
      o_vaddr = block_base + XLEN_W'(FETCH_BYTES);
    end
  end

endmodule

`default_nettype wire

// File: front_end_assert.sv
// ------------------------------------------------
// wishbone classic checks, bound into fetch_wb_master
// ------------------------------------------------
`default_nettype none

module front_end_assert
  import fetch_pkg::*;
(
  input wire logic              i_clk,
  input wire logic              i_arst_n,
  input wire logic              i_wb_cyc,
  input wire logic              i_wb_stb,
  input wire logic [XLEN_W-1:0] i_wb_adr,
  input wire logic              i_wb_ack
);
  timeunit 1ns;
  timeprecision 1ps;

  stb_needs_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_wb_stb |-> i_wb_cyc)
    else $error("wishbone stb high without cyc");

  // an abort drops stb, otherwise the address holds until ack
  adr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_wb_stb && !i_wb_ack) |=> (!i_wb_stb || $stable(i_wb_adr)))
    else $error("wishbone address moved while stb waited for ack");

  cyc_drop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_wb_cyc && i_wb_ack) |=> !i_wb_cyc)
    else $error("wishbone cyc still high in the cycle after ack");

endmodule

bind fetch_wb_master front_end_assert u_front_end_assert (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_wb_cyc (o_wb_cyc),
  .i_wb_stb (o_wb_stb),
  .i_wb_adr (o_wb_adr),
  .i_wb_ack (i_wb_ack)
);

`default_nettype wire

// File: front_end_top.sv
// ------------------------------------------------
// fetch front end top: trap csrs, address select
// and wishbone fetch master
// ------------------------------------------------
`default_nettype none

module front_end_top
  import fetch_pkg::*;
(
  input  wire logic                    i_clk,
  input  wire logic                    i_arst_n,

  // commit flush
  input  wire logic                    i_commit_flush,
  input  wire logic                    i_commit_int_valid,
  input  wire cause_u                  i_commit_cause,
  input  wire logic [XLEN_W-1:0]       i_commit_epc,

  // branch update
  input  wire logic                    i_br_update,
  input  wire logic                    i_br_dead,
  input  wire logic                    i_br_mispredict,
  input  wire logic [XLEN_W-1:0]       i_br_target,

  // csr write
  input  wire logic                    i_csr_we,
  input  wire logic [CSR_ADDR_W-1:0]   i_csr_addr,
  input  wire logic [XLEN_W-1:0]       i_csr_wdata,

  // wishbone
  output logic                         o_wb_cyc,
  output logic                         o_wb_stb,
  output logic      [XLEN_W-1:0]       o_wb_adr,
  output logic                         o_wb_we,
  input  wire logic                    i_wb_ack,
  input  wire logic [FETCH_DATA_W-1:0] i_wb_dat,

  // fetch result
  output logic                         o_fetch_valid,
  output logic      [XLEN_W-1:0]       o_fetch_vaddr,
  output logic      [FETCH_DATA_W-1:0] o_fetch_data,
  output logic                         o_int_flush_valid
);

  logic [XLEN_W-1:0]    mtvec, stvec, mepc, sepc, uepc;
  logic [MEDELEG_W-1:0] medeleg;
  logic [XLEN_W-1:0]    f0_vaddr;
  logic                 f0_req_ready;
  logic [XLEN_W-1:0]    next_vaddr;
  logic                 redirect;

  trap_csr_regs u_trap_csr_regs (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_csr_we    (i_csr_we),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .o_mtvec     (mtvec),
    .o_stvec     (stvec),
    .o_mepc      (mepc),
    .o_sepc      (sepc),
    .o_uepc      (uepc),
    .o_medeleg   (medeleg)
  );

  front_addr_gen u_front_addr_gen (
    .i_commit_flush     (i_commit_flush),
    .i_commit_int_valid (i_commit_int_valid),
    .i_commit_cause     (i_commit_cause),
    .i_commit_epc       (i_commit_epc),
    .i_br_update        (i_br_update),
    .i_br_dead          (i_br_dead),
    .i_br_mispredict    (i_br_mispredict),
    .i_br_target        (i_br_target),
    .i_mtvec            (mtvec),
    .i_stvec            (stvec),
    .i_mepc             (mepc),
    .i_sepc             (sepc),
    .i_uepc             (uepc),
    .i_medeleg          (medeleg),
    .i_f0_req_ready     (f0_req_ready),
    .i_f0_vaddr         (f0_vaddr),
    .o_vaddr            (next_vaddr),
    .o_redirect         (redirect),
    .o_int_flush_valid  (o_int_flush_valid)
  );

  fetch_wb_master u_fetch_wb_master (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_next_vaddr   (next_vaddr),
    .i_redirect     (redirect),
    .o_f0_vaddr     (f0_vaddr),
    .o_f0_req_ready (f0_req_ready),
    .o_wb_cyc       (o_wb_cyc),
    .o_wb_stb       (o_wb_stb),
    .o_wb_adr       (o_wb_adr),
    .o_wb_we        (o_wb_we),
    .i_wb_ack       (i_wb_ack),
    .i_wb_dat       (i_wb_dat),
    .o_fetch_valid  (o_fetch_valid),
    .o_fetch_vaddr  (o_fetch_vaddr),
    .o_fetch_data   (o_fetch_data)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_front_end --Mdir "$BUILD_DIR" -o sim_front_end \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_front_end" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// File: tb_front_end.sv
// ------------------------------------------------
// testbench for the fetch front end with random wait
// states, branch and commit redirects and csr writes
// ------------------------------------------------
`default_nettype none

module tb_front_end
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 4000;  // ~200 fetches at worst wait plus redirects

  logic clk, arst_n;
  logic commit_flush, commit_int_valid;
  cause_u commit_cause;
  logic [XLEN_W-1:0] commit_epc;
  logic br_update, br_dead, br_mispredict;
  logic [XLEN_W-1:0] br_target;
  logic csr_we;
  logic [CSR_ADDR_W-1:0] csr_addr;
  logic [XLEN_W-1:0] csr_wdata, wb_adr, fetch_vaddr;
  logic wb_cyc, wb_stb, wb_we, wb_ack, fetch_valid, int_flush_valid;
  logic [FETCH_DATA_W-1:0] wb_dat, fetch_data;

  // model copy of the trap csrs
  logic [XLEN_W-1:0] m_mtvec, m_stvec, m_mepc, m_sepc, m_uepc;
  logic [MEDELEG_W-1:0] m_medeleg;
  logic [XLEN_W-1:0] exp_addr;  // expected fetch address register
  int errors, fetch_cnt, cycle_cnt;
  logic [1:0] wait_left;
  logic stb_seen;
  logic [XLEN_W-1:0] adr_seen;

  front_end_top i_front_end_top (
    .i_clk (clk), .i_arst_n (arst_n),
    .i_commit_flush (commit_flush), .i_commit_int_valid (commit_int_valid),
    .i_commit_cause (commit_cause), .i_commit_epc (commit_epc),
    .i_br_update (br_update), .i_br_dead (br_dead),
    .i_br_mispredict (br_mispredict), .i_br_target (br_target),
    .i_csr_we (csr_we), .i_csr_addr (csr_addr), .i_csr_wdata (csr_wdata),
    .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr), .o_wb_we (wb_we),
    .i_wb_ack (wb_ack), .i_wb_dat (wb_dat),
    .o_fetch_valid (fetch_valid), .o_fetch_vaddr (fetch_vaddr),
    .o_fetch_data (fetch_data), .o_int_flush_valid (int_flush_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [XLEN_W-1:0] align_block(input logic [XLEN_W-1:0] addr);
    return addr & ~XLEN_W'(FETCH_BYTES - 1);
  endfunction

  // memory image that depends on every address bit
  function automatic logic [FETCH_DATA_W-1:0] block_data(input logic [XLEN_W-1:0] addr);
    return {addr ^ 32'h5a5a_c3c3, ~addr};
  endfunction

  function automatic logic is_int_code(input logic [CAUSE_W-1:0] code);
    return code inside {SUPER_SOFT_INT, MACHINE_SOFT_INT, SUPER_TIMER_INT,
                        MACHINE_TIMER_INT, SUPER_EXT_INT, MACHINE_EXT_INT};
  endfunction

  // expected fetch address after a redirect or after a reported block
  // (the stall hold never shows up here)
  function automatic logic [XLEN_W-1:0] next_addr(
    input logic flush, input logic int_valid, input logic [CAUSE_W-1:0] code,
    input logic [XLEN_W-1:0] epc, input logic br_live,
    input logic [XLEN_W-1:0] target, input logic [XLEN_W-1:0] cur);
    logic [XLEN_W-1:0] addr;
    addr = '0;  // unknown codes land at zero
    if (flush && int_valid) begin
      if (is_int_code(code)) begin
        addr = (m_mtvec & ~32'd1) + (XLEN_W'(code) << 2);
      end
    end else if (flush) begin
      case (code)
        SILENT_FLUSH:     addr = epc + 32'd4;
        SELF_KILL_REPLAY,
        ANOTHER_FLUSH:    addr = epc;
        MRET:             addr = m_mepc;
        SRET:             addr = m_sepc;
        URET:             addr = m_uepc;
        default: begin
          if (code < 5'd16 && code != 5'd10 && code != 5'd14) begin
            addr = m_medeleg[code[3:0]] ? m_stvec : m_mtvec;
          end
        end
      endcase
    end else if (br_live) begin
      addr = target;
    end else begin
      addr = align_block(cur) + XLEN_W'(FETCH_BYTES);
    end
    return addr;
  endfunction

  // ------------------------------------------------
  // wishbone memory responder
  // ------------------------------------------------
  always @(negedge clk) begin
    stb_seen = wb_cyc && wb_stb;
    adr_seen = wb_adr;
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack    <= 1'b0;
      wb_dat    <= '0;
      wait_left <= 2'd0;
    end else begin
      wb_ack <= 1'b0;
      if (stb_seen && !wb_ack) begin
        if (wait_left == 2'd0) begin
          wb_ack    <= 1'b1;
          wb_dat    <= block_data(adr_seen);
          wait_left <= 2'($urandom % 4);  // waits for the next transfer
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

  // ------------------------------------------------
  // checker sampling mid cycle
  // ------------------------------------------------
  always @(negedge clk) begin : check_proc
    logic br_live;
    logic exp_int;
    br_live = br_update && !br_dead && br_mispredict;
    exp_int = commit_flush && commit_int_valid && is_int_code(commit_cause.int_code);
    if (!arst_n) begin
      exp_addr  = RESET_VECTOR;
      m_mtvec   = '0;
      m_stvec   = '0;
      m_mepc    = '0;
      m_sepc    = '0;
      m_uepc    = '0;
      m_medeleg = '0;
    end else begin
      if (int_flush_valid !== exp_int) begin
        errors++;
        $display("MISMATCH o_int_flush_valid got %h expected %h", int_flush_valid, exp_int);
      end
      if (wb_we !== 1'b0) begin
        errors++;
        $display("MISMATCH o_wb_we got %h expected 0", wb_we);
      end
      if (commit_flush || br_live) begin
        if (fetch_valid) begin
          errors++;
          $display("block at %h reported in a redirect cycle", fetch_vaddr);
        end
        exp_addr = next_addr(commit_flush, commit_int_valid,
                             commit_cause.exc_code, commit_epc,
                             br_live, br_target, exp_addr);
      end else if (fetch_valid) begin
        if (fetch_vaddr !== exp_addr) begin
          errors++;
          $display("MISMATCH o_fetch_vaddr got %h expected %h", fetch_vaddr, exp_addr);
        end
        if (fetch_data !== block_data(align_block(exp_addr))) begin
          errors++;
          $display("MISMATCH o_fetch_data got %h expected %h",
                   fetch_data, block_data(align_block(exp_addr)));
        end
        fetch_cnt++;
        exp_addr = next_addr(1'b0, 1'b0, '0, '0, 1'b0, '0, exp_addr);
      end
      if (csr_we) begin  // seen by the next cycle only
        case (csr_addr)
          CSR_MTVEC:   m_mtvec   = csr_wdata;
          CSR_STVEC:   m_stvec   = csr_wdata & ~32'd3;
          CSR_MEPC:    m_mepc    = csr_wdata & ~32'd3;
          CSR_SEPC:    m_sepc    = csr_wdata & ~32'd3;
          CSR_UEPC:    m_uepc    = csr_wdata & ~32'd3;
          CSR_MEDELEG: m_medeleg = csr_wdata[MEDELEG_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------
  task automatic wait_fetches(input int n);
    int target;
    target = fetch_cnt + n;
    while (fetch_cnt < target) @(posedge clk);
  endtask

  task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN_W-1:0] data);
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_we    <= 1'b0;
  endtask

  task automatic send_branch(input logic dead, input logic mis, input logic [XLEN_W-1:0] tgt);
    @(posedge clk);
    br_update     <= 1'b1;
    br_dead       <= dead;
    br_mispredict <= mis;
    br_target     <= tgt;
    @(posedge clk);
    br_update     <= 1'b0;
  endtask

  // one cycle commit flush with an optional live mispredict beside it
  task automatic send_commit(input logic int_valid, input logic [CAUSE_W-1:0] code,
                             input logic [XLEN_W-1:0] epc, input logic with_br);
    @(posedge clk);
    commit_flush     <= 1'b1;
    commit_int_valid <= int_valid;
    if (int_valid) begin
      commit_cause.int_code <= code;
    end else begin
      commit_cause.exc_code <= code;
    end
    commit_epc    <= epc;
    br_update     <= with_br;
    br_dead       <= 1'b0;
    br_mispredict <= with_br;
    br_target     <= $urandom & 32'hffff_fffc;
    @(posedge clk);
    commit_flush     <= 1'b0;
    commit_int_valid <= 1'b0;
    br_update        <= 1'b0;
    br_mispredict    <= 1'b0;
  endtask

  initial begin : stimulus
    logic [CAUSE_W-1:0] int_codes [6];
    logic dead_b;
    logic mis_b;
    int_codes = '{SUPER_SOFT_INT, MACHINE_SOFT_INT, SUPER_TIMER_INT,
                  MACHINE_TIMER_INT, SUPER_EXT_INT, MACHINE_EXT_INT};
    void'($urandom(32'hbb6434ab));
    errors = 0;
    fetch_cnt = 0;
    arst_n = 1'b0;
    commit_flush = 1'b0;
    commit_int_valid = 1'b0;
    commit_cause = '0;
    commit_epc = '0;
    br_update = 1'b0;
    br_dead = 1'b0;
    br_mispredict = 1'b0;
    br_target = '0;
    csr_we = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    @(negedge clk);
    if (wb_cyc || wb_stb || fetch_valid || int_flush_valid) begin
      errors++;
      $display("bus or fetch flags active while in reset");
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    wait_fetches(24);  // straight line fetch from the reset vector
    write_csr(CSR_MTVEC, 32'h0000_8001);  // bit 0 set to see it cleared for vectoring
    write_csr(CSR_STVEC, 32'h0004_0000 | ($urandom & 32'h0000_ffff));
    write_csr(CSR_MEPC, $urandom);
    write_csr(CSR_SEPC, $urandom);
    write_csr(CSR_UEPC, $urandom);
    write_csr(CSR_MEDELEG, $urandom);

    for (int i = 0; i < 12; i++) begin
      dead_b = ($urandom % 4) == 0;
      mis_b  = ($urandom % 4) != 0;
      send_branch(dead_b, mis_b, $urandom & 32'hffff_fffc);
      wait_fetches(2);
    end
    for (int i = 0; i < 6; i++) begin
      send_commit(1'b1, int_codes[i], $urandom, 1'b0);
      wait_fetches(2);
    end
    for (int i = 0; i < 6; i++) begin
      send_commit(1'b0, CAUSE_W'(16 + i), $urandom & 32'hffff_fffc, 1'b0);
      wait_fetches(2);
    end
    // every exception code twice with medeleg flipped in between
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 16; i++) begin
        send_commit(1'b0, CAUSE_W'(i), $urandom, 1'b0);
        wait_fetches(2);
      end
      write_csr(CSR_MEDELEG, {16'h0, ~m_medeleg});
    end
    for (int i = 0; i < 6; i++) begin
      send_commit(1'b0, CAUSE_W'(16 + ($urandom % 6)), $urandom & 32'hffff_fffc, 1'b1);
      wait_fetches(2);
    end

    repeat (4) @(posedge clk);
    $display("fetch blocks checked %0d, errors %0d", fetch_cnt, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with %0d blocks checked, errors %0d",
             cycle_cnt, fetch_cnt, errors);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: trap_csr_regs.sv
// ------------------------------------------------
// trap vector and exception pc registers, written
// through a plain select / data port
// ------------------------------------------------
`default_nettype none

module trap_csr_regs
  import fetch_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_arst_n,

  // write port
  input  wire logic                  i_csr_we,
  input  wire logic [CSR_ADDR_W-1:0] i_csr_addr,
  input  wire logic [XLEN_W-1:0]     i_csr_wdata,

  // register values to the address generator
  output logic      [XLEN_W-1:0]     o_mtvec,
  output logic      [XLEN_W-1:0]     o_stvec,
  output logic      [XLEN_W-1:0]     o_mepc,
  output logic      [XLEN_W-1:0]     o_sepc,
  output logic      [XLEN_W-1:0]     o_uepc,
  output logic      [MEDELEG_W-1:0]  o_medeleg
);

  logic [XLEN_W-1:0]    mtvec_q;
  logic [XLEN_W-1:0]    stvec_q;
  logic [XLEN_W-1:0]    mepc_q;
  logic [XLEN_W-1:0]    sepc_q;
  logic [XLEN_W-1:0]    uepc_q;
  logic [MEDELEG_W-1:0] medeleg_q;
  logic [XLEN_W-1:0]    wdata_word;  // word aligned copy of the write data

  assign wdata_word = {i_csr_wdata[XLEN_W-1:2], 2'b00};

  // ------------------------------------------------
  // register file
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mtvec_q   <= '0;
      stvec_q   <= '0;
      mepc_q    <= '0;
      sepc_q    <= '0;
      uepc_q    <= '0;
      medeleg_q <= '0;
    end else if (i_csr_we) begin
      case (i_csr_addr)
        CSR_MTVEC:   mtvec_q   <= i_csr_wdata;  // bit 0 kept, cleared at use
        CSR_STVEC:   stvec_q   <= wdata_word;
        CSR_MEPC:    mepc_q    <= wdata_word;
        CSR_SEPC:    sepc_q    <= wdata_word;
        CSR_UEPC:    uepc_q    <= wdata_word;
        CSR_MEDELEG: medeleg_q <= i_csr_wdata[MEDELEG_W-1:0];
        default: ;  // 6 and 7 select nothing
      endcase
    end
  end

  assign o_mtvec   = mtvec_q;
  assign o_stvec   = stvec_q;
  assign o_mepc    = mepc_q;
  assign o_sepc    = sepc_q;
  assign o_uepc    = uepc_q;
  assign o_medeleg = medeleg_q;

endmodule

`default_nettype wire
